// File: hw/hash_table_pkg.sv
`default_nettype none

package hash_table_pkg;

    localparam int KEY_WIDTH    = 32;
    localparam int DATA_WIDTH   = 16;
    localparam int INDEX_WIDTH  = 8;
    localparam int OPCODE_WIDTH = 4;

    // one entry per index value
    localparam int TABLE_DEPTH = 2 ** INDEX_WIDTH;

    typedef logic [KEY_WIDTH-1:0]    key_t;
    typedef logic [DATA_WIDTH-1:0]   data_t;
    typedef logic [INDEX_WIDTH-1:0]  index_t;
    typedef logic [OPCODE_WIDTH-1:0] opcode_t;

    // unlisted codes act as nop
    localparam opcode_t OP_NOP    = 4'd0;
    localparam opcode_t OP_SEARCH = 4'd1;
    localparam opcode_t OP_INSERT = 4'd2;
    localparam opcode_t OP_DELETE = 4'd3;

    // xor of the key bytes
    function automatic index_t fold_index(input key_t key);
        index_t idx;
        idx = '0;
        for (int b = 0; b < KEY_WIDTH / INDEX_WIDTH; b++) begin
            idx = idx ^ key[b*INDEX_WIDTH +: INDEX_WIDTH];
        end
        return idx;
    endfunction

endpackage

`default_nettype wire

// File: hw/hash_front.sv
`timescale 1ns/10ps
`default_nettype none

module hash_front #(
    parameter int LANE_NUM = 4
) (
    input  wire logic                    clk,
    input  wire logic                    rst,

    input  wire logic                    op_valid_i    [LANE_NUM],
    input  wire hash_table_pkg::opcode_t opcode_i      [LANE_NUM],
    input  wire hash_table_pkg::key_t    key_i         [LANE_NUM],
    input  wire hash_table_pkg::data_t   insert_data_i [LANE_NUM],

    output logic                         s1_valid_o    [LANE_NUM],
    output hash_table_pkg::opcode_t      s1_opcode_o   [LANE_NUM],
    output hash_table_pkg::key_t         s1_key_o      [LANE_NUM],
    output hash_table_pkg::data_t        s1_data_o     [LANE_NUM],
    output hash_table_pkg::index_t       s1_index_o    [LANE_NUM]
);

    hash_table_pkg::index_t in_index [LANE_NUM];

    // fold ahead of the s1 register
    always_comb begin
        for (int l = 0; l < LANE_NUM; l++) begin
            in_index[l] = hash_table_pkg::fold_index(key_i[l]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int l = 0; l < LANE_NUM; l++) begin
                s1_valid_o[l] <= 1'b0;
            end
        end else begin
            for (int l = 0; l < LANE_NUM; l++) begin
                s1_valid_o[l] <= op_valid_i[l];
            end
        end
    end

    // payload follows valid
    always_ff @(posedge clk) begin
        for (int l = 0; l < LANE_NUM; l++) begin
            s1_opcode_o[l] <= opcode_i[l];
            s1_key_o[l]    <= key_i[l];
            s1_data_o[l]   <= insert_data_i[l];
            s1_index_o[l]  <= in_index[l];
        end
    end

endmodule

`default_nettype wire

// File: hw/table_bank.sv
`timescale 1ns/10ps
`default_nettype none

module table_bank #(
    parameter int LANE_NUM = 4
) (
    input  wire logic                   clk,
    input  wire logic                   rst,

    // read port, own lane only
    input  wire hash_table_pkg::index_t rd_index_i,

    // broadcast writes from every lane
    input  wire logic                   wr_en_i    [LANE_NUM],
    input  wire hash_table_pkg::index_t wr_index_i [LANE_NUM],
    input  wire logic                   wr_valid_i [LANE_NUM],
    input  wire hash_table_pkg::key_t   wr_key_i   [LANE_NUM],
    input  wire hash_table_pkg::data_t  wr_data_i  [LANE_NUM],

    output logic                        rd_valid_o,
    output hash_table_pkg::key_t        rd_key_o,
    output hash_table_pkg::data_t       rd_data_o
);

    logic [hash_table_pkg::TABLE_DEPTH-1:0] valid_q;
    hash_table_pkg::key_t                   key_mem  [hash_table_pkg::TABLE_DEPTH];
    hash_table_pkg::data_t                  data_mem [hash_table_pkg::TABLE_DEPTH];

    // highest lane first so lane 0 lands last and wins
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else begin
            for (int l = LANE_NUM - 1; l >= 0; l--) begin
                if (wr_en_i[l]) begin
                    valid_q[wr_index_i[l]] <= wr_valid_i[l];
                end
            end
        end
    end

    // same lane order as the valid bits
    always_ff @(posedge clk) begin
        for (int l = LANE_NUM - 1; l >= 0; l--) begin
            if (wr_en_i[l]) begin
                key_mem[wr_index_i[l]]  <= wr_key_i[l];
                data_mem[wr_index_i[l]] <= wr_data_i[l];
            end
        end
    end

    // synchronous read, old contents on a same-edge write
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid_o <= 1'b0;
        end else begin
            rd_valid_o <= valid_q[rd_index_i];
        end
    end

    always_ff @(posedge clk) begin
        rd_key_o  <= key_mem[rd_index_i];
        rd_data_o <= data_mem[rd_index_i];
    end

endmodule

`default_nettype wire

// File: hw/result_stage.sv
`timescale 1ns/10ps
`default_nettype none

module result_stage #(
    parameter int LANE_NUM = 4
) (
    input  wire logic                    clk,
    input  wire logic                    rst,

    input  wire logic                    s1_valid_i  [LANE_NUM],
    input  wire hash_table_pkg::opcode_t s1_opcode_i [LANE_NUM],
    input  wire hash_table_pkg::key_t    s1_key_i    [LANE_NUM],
    input  wire hash_table_pkg::data_t   s1_data_i   [LANE_NUM],
    input  wire hash_table_pkg::index_t  s1_index_i  [LANE_NUM],

    // bank read, lines up with s2
    input  wire logic                    rd_valid_i  [LANE_NUM],
    input  wire hash_table_pkg::key_t    rd_key_i    [LANE_NUM],
    input  wire hash_table_pkg::data_t   rd_data_i   [LANE_NUM],

    output logic                         wr_en_o     [LANE_NUM],
    output hash_table_pkg::index_t       wr_index_o  [LANE_NUM],
    output logic                         wr_valid_o  [LANE_NUM],
    output hash_table_pkg::key_t         wr_key_o    [LANE_NUM],
    output hash_table_pkg::data_t        wr_data_o   [LANE_NUM],

    output logic                         op_valid_o  [LANE_NUM],
    output logic                         res_valid_o [LANE_NUM],
    output hash_table_pkg::opcode_t      opcode_o    [LANE_NUM],
    output hash_table_pkg::key_t         key_o       [LANE_NUM],
    output hash_table_pkg::data_t        r_data_o    [LANE_NUM]
);

    logic                    s2_valid  [LANE_NUM];
    hash_table_pkg::opcode_t s2_opcode [LANE_NUM];
    hash_table_pkg::key_t    s2_key    [LANE_NUM];
    hash_table_pkg::data_t   s2_data   [LANE_NUM];
    hash_table_pkg::index_t  s2_index  [LANE_NUM];

    logic is_search [LANE_NUM];
    logic is_insert [LANE_NUM];
    logic is_delete [LANE_NUM];
    logic key_hit   [LANE_NUM];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int l = 0; l < LANE_NUM; l++) begin
                s2_valid[l] <= 1'b0;
            end
        end else begin
            for (int l = 0; l < LANE_NUM; l++) begin
                s2_valid[l] <= s1_valid_i[l];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int l = 0; l < LANE_NUM; l++) begin
            s2_opcode[l] <= s1_opcode_i[l];
            s2_key[l]    <= s1_key_i[l];
            s2_data[l]   <= s1_data_i[l];
            s2_index[l]  <= s1_index_i[l];
        end
    end

    // decode and key compare
    always_comb begin
        for (int l = 0; l < LANE_NUM; l++) begin
            is_search[l] = s2_valid[l] && (s2_opcode[l] == hash_table_pkg::OP_SEARCH);
            is_insert[l] = s2_valid[l] && (s2_opcode[l] == hash_table_pkg::OP_INSERT);
            is_delete[l] = s2_valid[l] && (s2_opcode[l] == hash_table_pkg::OP_DELETE);
            key_hit[l]   = rd_valid_i[l] && (rd_key_i[l] == s2_key[l]);
        end
    end

    // delete clears the entry only when the stored key matches
    always_comb begin
        for (int l = 0; l < LANE_NUM; l++) begin
            wr_en_o[l]    = is_insert[l] || (is_delete[l] && key_hit[l]);
            wr_index_o[l] = s2_index[l];
            wr_valid_o[l] = is_insert[l];
            wr_key_o[l]   = s2_key[l];
            wr_data_o[l]  = is_insert[l] ? s2_data[l] : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int l = 0; l < LANE_NUM; l++) begin
                op_valid_o[l]  <= 1'b0;
                res_valid_o[l] <= 1'b0;
            end
        end else begin
            for (int l = 0; l < LANE_NUM; l++) begin
                op_valid_o[l]  <= s2_valid[l];
                res_valid_o[l] <= key_hit[l] && (is_search[l] || is_delete[l]);
            end
        end
    end

    // echo opcode and key, data only on a search hit
    always_ff @(posedge clk) begin
        for (int l = 0; l < LANE_NUM; l++) begin
            opcode_o[l] <= s2_opcode[l];
            key_o[l]    <= s2_key[l];
            r_data_o[l] <= (is_search[l] && key_hit[l]) ? rd_data_i[l] : '0;
        end
    end

endmodule

`default_nettype wire

// File: hw/hash_table_top.sv
`timescale 1ns/10ps
`default_nettype none

module hash_table_top #(
    parameter int LANE_NUM = 4
) (
    input  wire logic                    clk,
    input  wire logic                    rst,

    input  wire logic                    op_valid_i    [LANE_NUM],
    input  wire hash_table_pkg::opcode_t opcode_i      [LANE_NUM],
    input  wire hash_table_pkg::key_t    key_i         [LANE_NUM],
    input  wire hash_table_pkg::data_t   insert_data_i [LANE_NUM],

    output logic                         op_valid_o    [LANE_NUM],
    output logic                         res_valid_o   [LANE_NUM],
    output hash_table_pkg::opcode_t      opcode_o      [LANE_NUM],
    output hash_table_pkg::key_t         key_o         [LANE_NUM],
    output hash_table_pkg::data_t        r_data_o      [LANE_NUM]
);

    // s1 stage
    logic                    s1_valid  [LANE_NUM];
    hash_table_pkg::opcode_t s1_opcode [LANE_NUM];
    hash_table_pkg::key_t    s1_key    [LANE_NUM];
    hash_table_pkg::data_t   s1_data   [LANE_NUM];
    hash_table_pkg::index_t  s1_index  [LANE_NUM];

    // per-lane bank read
    logic                    rd_valid  [LANE_NUM];
    hash_table_pkg::key_t    rd_key    [LANE_NUM];
    hash_table_pkg::data_t   rd_data   [LANE_NUM];

    // write broadcast to all banks
    logic                    wr_en     [LANE_NUM];
    hash_table_pkg::index_t  wr_index  [LANE_NUM];
    logic                    wr_valid  [LANE_NUM];
    hash_table_pkg::key_t    wr_key    [LANE_NUM];
    hash_table_pkg::data_t   wr_data   [LANE_NUM];

    hash_front #(
        .LANE_NUM(LANE_NUM)
    ) u_front (
        .clk          (clk),
        .rst          (rst),
        .op_valid_i   (op_valid_i),
        .opcode_i     (opcode_i),
        .key_i        (key_i),
        .insert_data_i(insert_data_i),
        .s1_valid_o   (s1_valid),
        .s1_opcode_o  (s1_opcode),
        .s1_key_o     (s1_key),
        .s1_data_o    (s1_data),
        .s1_index_o   (s1_index)
    );

    // one full table copy per lane
    for (genvar l = 0; l < LANE_NUM; l++) begin : g_bank
        table_bank #(
            .LANE_NUM(LANE_NUM)
        ) u_bank (
            .clk       (clk),
            .rst       (rst),
            .rd_index_i(s1_index[l]),
            .wr_en_i   (wr_en),
            .wr_index_i(wr_index),
            .wr_valid_i(wr_valid),
            .wr_key_i  (wr_key),
            .wr_data_i (wr_data),
            .rd_valid_o(rd_valid[l]),
            .rd_key_o  (rd_key[l]),
            .rd_data_o (rd_data[l])
        );
    end

    result_stage #(
        .LANE_NUM(LANE_NUM)
    ) u_result (
        .clk        (clk),
        .rst        (rst),
        .s1_valid_i (s1_valid),
        .s1_opcode_i(s1_opcode),
        .s1_key_i   (s1_key),
        .s1_data_i  (s1_data),
        .s1_index_i (s1_index),
        .rd_valid_i (rd_valid),
        .rd_key_i   (rd_key),
        .rd_data_i  (rd_data),
        .wr_en_o    (wr_en),
        .wr_index_o (wr_index),
        .wr_valid_o (wr_valid),
        .wr_key_o   (wr_key),
        .wr_data_o  (wr_data),
        .op_valid_o (op_valid_o),
        .res_valid_o(res_valid_o),
        .opcode_o   (opcode_o),
        .key_o      (key_o),
        .r_data_o   (r_data_o)
    );

endmodule

`default_nettype wire

// File: tests/tb_hash_model.svh
`ifndef TB_HASH_MODEL_SVH
`define TB_HASH_MODEL_SVH

localparam int MAX_CYC = 512;

// one table stands for every bank copy
logic                   m_valid [hash_table_pkg::TABLE_DEPTH];
hash_table_pkg::key_t   m_key   [hash_table_pkg::TABLE_DEPTH];
hash_table_pkg::data_t  m_data  [hash_table_pkg::TABLE_DEPTH];

// writes held back two cycles, slot is issue cycle mod 2
logic                   pend_en    [2][LANE_NUM];
hash_table_pkg::index_t pend_index [2][LANE_NUM];
logic                   pend_valid [2][LANE_NUM];
hash_table_pkg::key_t   pend_key   [2][LANE_NUM];
hash_table_pkg::data_t  pend_data  [2][LANE_NUM];

// expected outputs by output cycle
logic                    exp_op_valid  [MAX_CYC][LANE_NUM];
logic                    exp_res_valid [MAX_CYC][LANE_NUM];
hash_table_pkg::opcode_t exp_opcode    [MAX_CYC][LANE_NUM];
hash_table_pkg::key_t    exp_key       [MAX_CYC][LANE_NUM];
hash_table_pkg::data_t   exp_r_data    [MAX_CYC][LANE_NUM];

logic [15:0] lfsr_state = 16'd38;

function automatic hash_table_pkg::index_t key_to_index(input hash_table_pkg::key_t key);
    return key[31:24] ^ key[23:16] ^ key[15:8] ^ key[7:0];
endfunction

function automatic void model_clear();
    for (int i = 0; i < hash_table_pkg::TABLE_DEPTH; i++) begin
        m_valid[i] = 1'b0;
    end
    for (int l = 0; l < LANE_NUM; l++) begin
        pend_en[0][l] = 1'b0;
        pend_en[1][l] = 1'b0;
        for (int c = 0; c < MAX_CYC; c++) begin
            exp_op_valid[c][l]  = 1'b0;
            exp_res_valid[c][l] = 1'b0;
        end
    end
endfunction

// writes from two cycles back, lowest lane last so it wins
function automatic void apply_old_writes(input int issue);
    int slot;
    slot = issue % 2;
    for (int l = LANE_NUM - 1; l >= 0; l--) begin
        if (pend_en[slot][l]) begin
            m_valid[pend_index[slot][l]] = pend_valid[slot][l];
            m_key[pend_index[slot][l]]   = pend_key[slot][l];
            m_data[pend_index[slot][l]]  = pend_data[slot][l];
        end
    end
endfunction

function automatic void expect_result(input int issue, input int lane, input logic valid,
                                      input hash_table_pkg::opcode_t op,
                                      input hash_table_pkg::key_t key,
                                      input hash_table_pkg::data_t data);
    int                     slot;
    int                     oc;
    hash_table_pkg::index_t idx;
    logic                   hit;
    logic                   is_search;
    logic                   is_insert;
    logic                   is_delete;
    slot      = issue % 2;
    oc        = issue + 3;
    idx       = key_to_index(key);
    hit       = m_valid[idx] && (m_key[idx] == key);
    is_search = valid && (op == hash_table_pkg::OP_SEARCH);
    is_insert = valid && (op == hash_table_pkg::OP_INSERT);
    is_delete = valid && (op == hash_table_pkg::OP_DELETE);
    exp_op_valid[oc][lane]  = valid;
    exp_res_valid[oc][lane] = hit && (is_search || is_delete);
    exp_opcode[oc][lane]    = op;
    exp_key[oc][lane]       = key;
    exp_r_data[oc][lane]    = (is_search && hit) ? m_data[idx] : '0;
    pend_en[slot][lane]    = is_insert || (is_delete && hit);
    pend_index[slot][lane] = idx;
    pend_valid[slot][lane] = is_insert;
    pend_key[slot][lane]   = key;
    pend_data[slot][lane]  = is_insert ? data : '0;
endfunction

// x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = {lfsr_state[14:0],
                      lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10]};
        v = {v[30:0], lfsr_state[0]};
    end
    return v;
endfunction

`endif

// File: tests/tb_hash_table.sv
`timescale 1ns/10ps
`default_nettype none

module tb_hash_table;

    localparam int LANE_NUM    = 4;
    localparam int RAND_CYCLES = 300;
    localparam int DRAIN_LIMIT = 20;

    logic                    clk = 1'b0;
    logic                    rst;
    logic                    op_valid_i    [LANE_NUM];
    hash_table_pkg::opcode_t opcode_i      [LANE_NUM];
    hash_table_pkg::key_t    key_i         [LANE_NUM];
    hash_table_pkg::data_t   insert_data_i [LANE_NUM];
    logic                    op_valid_o    [LANE_NUM];
    logic                    res_valid_o   [LANE_NUM];
    hash_table_pkg::opcode_t opcode_o      [LANE_NUM];
    hash_table_pkg::key_t    key_o         [LANE_NUM];
    hash_table_pkg::data_t   r_data_o      [LANE_NUM];

    // operations for the next cycle
    logic                    st_valid  [LANE_NUM];
    hash_table_pkg::opcode_t st_opcode [LANE_NUM];
    hash_table_pkg::key_t    st_key    [LANE_NUM];
    hash_table_pkg::data_t   st_data   [LANE_NUM];

    int cyc      = 0;
    int sent_ops = 0;
    int seen_ops = 0;

    // pairs 0/1, 2/3 and 4/5 fold to one index
    hash_table_pkg::key_t key_pool [8];

    `include "tb_hash_model.svh"

    hash_table_top #(
        .LANE_NUM(LANE_NUM)
    ) UUT (
        .clk          (clk),
        .rst          (rst),
        .op_valid_i   (op_valid_i),
        .opcode_i     (opcode_i),
        .key_i        (key_i),
        .insert_data_i(insert_data_i),
        .op_valid_o   (op_valid_o),
        .res_valid_o  (res_valid_o),
        .opcode_o     (opcode_o),
        .key_o        (key_o),
        .r_data_o     (r_data_o)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic report_value(input string name, input int lane,
                                input logic [31:0] got, input logic [31:0] exp);
        stop_with_failure($sformatf("ERROR at %0t: lane %0d %s is %0h, expected %0h",
                                    $time, lane, name, got, exp));
    endtask

    task automatic stage_op(input int lane, input hash_table_pkg::opcode_t op,
                            input hash_table_pkg::key_t key, input hash_table_pkg::data_t data);
        st_valid[lane]  = 1'b1;
        st_opcode[lane] = op;
        st_key[lane]    = key;
        st_data[lane]   = data;
    endtask

    // 9 is an unlisted code and must act as a nop
    task automatic stage_random_cycle();
        logic [2:0] op_sel;
        for (int l = 0; l < LANE_NUM; l++) begin
            op_sel       = 3'(rand_bits(3));
            st_valid[l]  = (rand_bits(2) != 0);
            st_opcode[l] = (op_sel == 3'd7) ? 4'd9 : 4'(op_sel[1:0]);
            st_key[l]    = key_pool[rand_bits(3)];
            st_data[l]   = 16'(rand_bits(16));
        end
    endtask

    // present staged ops and predict their results, then step to edge plus 1 ns
    task automatic run_cycle();
        if (cyc + 3 >= MAX_CYC) begin
            stop_with_failure("stimulus ran past the expected result buffer");
        end else begin
            apply_old_writes(cyc);
            for (int l = 0; l < LANE_NUM; l++) begin
                op_valid_i[l]    = st_valid[l];
                opcode_i[l]      = st_opcode[l];
                key_i[l]         = st_key[l];
                insert_data_i[l] = st_data[l];
                expect_result(cyc, l, st_valid[l], st_opcode[l], st_key[l], st_data[l]);
                if (st_valid[l]) begin
                    sent_ops++;
                end
                st_valid[l] = 1'b0;
            end
            @(posedge clk);
            #1;
        end
    endtask

    task automatic drain_outputs();
        int waited;
        waited = 0;
        while (seen_ops < sent_ops) begin
            if (waited >= DRAIN_LIMIT) begin
                stop_with_failure("timeout: some issued operations never came out");
            end else begin
                run_cycle();
                waited++;
            end
        end
    endtask

    task automatic check_outputs(input int c);
        for (int l = 0; l < LANE_NUM; l++) begin
            assert (op_valid_o[l] === exp_op_valid[c][l])
                else report_value("op_valid_o", l, op_valid_o[l], exp_op_valid[c][l]);
            assert (res_valid_o[l] === exp_res_valid[c][l])
                else report_value("res_valid_o", l, res_valid_o[l], exp_res_valid[c][l]);
            if (exp_op_valid[c][l]) begin
                seen_ops++;
                assert (opcode_o[l] === exp_opcode[c][l])
                    else report_value("opcode_o", l, opcode_o[l], exp_opcode[c][l]);
                assert (key_o[l] === exp_key[c][l])
                    else report_value("key_o", l, key_o[l], exp_key[c][l]);
                assert (r_data_o[l] === exp_r_data[c][l])
                    else report_value("r_data_o", l, r_data_o[l], exp_r_data[c][l]);
            end
        end
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (cyc >= 1 && cyc < MAX_CYC) begin
            check_outputs(cyc);
        end
    end

    initial begin
        rst = 1'b1;
        for (int l = 0; l < LANE_NUM; l++) begin
            op_valid_i[l]    = 1'b0;
            opcode_i[l]      = hash_table_pkg::OP_NOP;
            key_i[l]         = '0;
            insert_data_i[l] = '0;
            st_valid[l]      = 1'b0;
            st_opcode[l]     = hash_table_pkg::OP_NOP;
            st_key[l]        = '0;
            st_data[l]       = '0;
        end
        key_pool = '{32'h1234_5678, 32'h7856_3412, 32'hA5A5_0000, 32'h0000_0000,
                     32'hDEAD_BEEF, 32'hEFBE_ADDE, 32'h0000_0001, 32'hCAFE_F00D};
        model_clear();
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        // empty table
        stage_op(0, hash_table_pkg::OP_SEARCH, key_pool[0], 16'h0);
        stage_op(1, hash_table_pkg::OP_DELETE, key_pool[4], 16'h0);
        run_cycle();
        stage_op(0, hash_table_pkg::OP_INSERT, key_pool[0], 16'h1111);
        run_cycle();
        run_cycle();
        stage_op(2, hash_table_pkg::OP_SEARCH, key_pool[0], 16'h0);
        run_cycle();
        // delete present and absent keys
        stage_op(1, hash_table_pkg::OP_DELETE, key_pool[0], 16'h0);
        stage_op(0, hash_table_pkg::OP_DELETE, key_pool[6], 16'h0);
        run_cycle();
        run_cycle();
        stage_op(3, hash_table_pkg::OP_SEARCH, key_pool[0], 16'h0);
        run_cycle();
        // same key on every lane at once
        for (int l = 0; l < LANE_NUM; l++) begin
            stage_op(l, hash_table_pkg::OP_INSERT, key_pool[4], 16'hA000 | 16'(l));
        end
        run_cycle();
        run_cycle();
        stage_op(3, hash_table_pkg::OP_SEARCH, key_pool[4], 16'h0);
        run_cycle();
        // eviction at a shared index
        stage_op(1, hash_table_pkg::OP_INSERT, key_pool[2], 16'h2222);
        run_cycle();
        run_cycle();
        stage_op(2, hash_table_pkg::OP_INSERT, key_pool[3], 16'h3333);
        run_cycle();
        run_cycle();
        stage_op(0, hash_table_pkg::OP_SEARCH, key_pool[2], 16'h0);
        stage_op(1, hash_table_pkg::OP_SEARCH, key_pool[3], 16'h0);
        run_cycle();
        drain_outputs();

        repeat (RAND_CYCLES) begin
            stage_random_cycle();
            run_cycle();
        end
        drain_outputs();

        if (sent_ops > 0 && seen_ops == sent_ops) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("Test failures found");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+tests
hw/hash_table_pkg.sv
hw/hash_front.sv
hw/table_bank.sv
hw/result_stage.sv
hw/hash_table_top.sv
tests/tb_hash_table.sv
